//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := ps2_host_tb
FILELIST  := ps2_host.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

//--- dv/ps2_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_clk_gen #(
  parameter int unsigned period_ns  = 40,
  parameter int unsigned rst_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;                       // held from time zero
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- dv/ps2_host_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_asserts (
  input logic clk,
  input logic rst,
  input logic rx_valid,
  input logic err,
  input logic busy,
  input logic ps2_clk_oe,
  input logic ps2_data_oe,
  input logic ps2_data_out
);

  ////////////////////////////// strobes
  a_rx_err_excl: assert property (@(posedge clk) disable iff (rst) !(rx_valid && err))
    else $error("rx_valid and err high together");
  a_rx_single:   assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else $error("rx_valid longer than one cycle");
  a_err_single:  assert property (@(posedge clk) disable iff (rst) err |=> !err)
    else $error("err longer than one cycle");

  // clock hold only inside a transmit
  a_oe_busy: assert property (@(posedge clk) disable iff (rst) ps2_clk_oe |-> busy)
    else $error("ps2_clk_oe without busy");

  ////////////////////////////// reset levels
  a_rst_quiet: assert property (@(posedge clk) rst |-> (!ps2_clk_oe && !ps2_data_oe &&
                                ps2_data_out && !rx_valid && !err && !busy))
    else $error("outputs active during reset");

endmodule

bind ps2_host ps2_host_asserts i_asserts (
  .clk(clk), .rst(rst), .rx_valid(rx_valid), .err(err), .busy(busy),
  .ps2_clk_oe(ps2_clk_oe), .ps2_data_oe(ps2_data_oe), .ps2_data_out(ps2_data_out)
);

`default_nettype wire

//--- dv/ps2_host_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_checker #(
  parameter int unsigned rts_hold_cycles   = 40,
  parameter int unsigned data_setup_cycles = 10
) (
  input  logic                clk,
  input  logic                test_start,  // one cycle at the start of each test
  input  logic                test_end,
  input  int                  test_kind,
  input  ps2_pkg::ps2_byte_t  exp_byte,
  input  ps2_pkg::ps2_frame_t exp_frame,
  input  ps2_pkg::ps2_frame_t dev_frame,   // bits the device model sampled
  input  ps2_pkg::ps2_byte_t  rx_data,
  input  logic                rx_valid,
  input  logic                err,
  input  logic                busy,
  input  logic                ps2_clk_oe,
  input  logic                ps2_data_oe,
  input  logic                ps2_data_out,
  output int                  pass_cnt,
  output int                  fail_cnt
);

  localparam int exp_oe_cycles = rts_hold_cycles + 1 + data_setup_cycles + 2;

  int                 n_rx;
  int                 n_err;
  int                 oe_cycles;      // cycles the clock line was held
  logic               data_low_seen;  // start bit driven under the hold
  ps2_pkg::ps2_byte_t last_rx;
  logic               test_ok;

  function automatic string kind_name(input int kind);
    case (kind)
      0:       return "reset";
      1:       return "rx";
      2:       return "rx_bad_parity";
      3:       return "rts";
      4:       return "tx_ack";
      default: return "tx_no_ack";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h actual %0h", kind_name(test_kind), what, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic missing(input string what);
    $display("test %s: %s", kind_name(test_kind), what);
    test_ok = 1'b0;
  endtask

  ////////////////////////////// watch on the falling edge, values are settled
  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  always @(negedge clk) begin
    if (test_start) begin
      n_rx          = 0;
      n_err         = 0;
      oe_cycles     = 0;
      data_low_seen = 1'b0;
      last_rx       = '0;
    end else begin
      if (rx_valid) begin
        n_rx++;
        last_rx = rx_data;          // updates on the same edge as the strobe
      end
      if (err) n_err++;
      if (ps2_clk_oe) begin
        oe_cycles++;
        if (ps2_data_oe && !ps2_data_out) data_low_seen = 1'b1;
      end
    end
    if (test_end) begin
      test_ok = 1'b1;
      case (test_kind)
        0: begin
          check_value("busy", 32'h0, 32'(busy));
          check_value("err", 32'h0, 32'(err));
          check_value("rx_valid", 32'h0, 32'(rx_valid));
          check_value("ps2_clk_oe", 32'h0, 32'(ps2_clk_oe));
          check_value("ps2_data_oe", 32'h0, 32'(ps2_data_oe));
        end
        1: begin
          if (n_rx == 0) missing("no rx_valid pulse seen for the frame");
          else check_value("rx_valid count", 32'd1, 32'(n_rx));
          check_value("rx_data", 32'(exp_byte), 32'(last_rx));
          check_value("err count", 32'd0, 32'(n_err));
        end
        2: begin
          if (n_err == 0) missing("no err pulse seen for the bad parity frame");
          else check_value("err count", 32'd1, 32'(n_err));
          check_value("rx_valid count", 32'd0, 32'(n_rx));
          check_value("rx_data", 32'(exp_byte), 32'(rx_data));
        end
        3: begin
          check_value("clock hold cycles", 32'(exp_oe_cycles), 32'(oe_cycles));
          if (!data_low_seen) missing("data line not pulled low before clock release");
          check_value("err count", 32'd0, 32'(n_err));
        end
        4: begin
          check_value("device frame", 32'(exp_frame), 32'(dev_frame));
          check_value("err count", 32'd0, 32'(n_err));
          check_value("busy", 32'h0, 32'(busy));
        end
        default: begin
          if (n_err == 0) missing("no err pulse seen without acknowledge");
          else check_value("err count", 32'd1, 32'(n_err));
          check_value("busy", 32'h0, 32'(busy));
        end
      endcase
      if (test_ok) begin
        $display("test %s passed", kind_name(test_kind));
        pass_cnt++;
      end else begin
        $display("test %s failed", kind_name(test_kind));
        fail_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/ps2_host_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_tb;

  localparam int unsigned rts_hold   = 40;
  localparam int unsigned data_setup = 10;
  localparam int unsigned release_c  = 8;
  localparam int unsigned debounce   = 3;
  localparam int          n_tests    = 9;     // reset, 4 rx, bad parity, 3 tx
  localparam int          n_frames   = 8;     // 5 received, 3 sent
  localparam int          half_clk   = 30;    // device clock half period in clk cycles
  // each frame is 11 device clocks and a send adds the request and the settle time
  localparam int timeout_cycles =
    2 * (n_frames * 11 * 2 * half_clk + n_frames * (rts_hold + data_setup + release_c + 200));

  logic                clk;
  logic                rst;
  logic                tx_valid;
  ps2_pkg::ps2_byte_t  tx_data;
  logic                dev_clk;     // device side of the wired-AND lines
  logic                dev_data;
  logic                ps2_clk_line;
  logic                ps2_data_line;
  logic                ps2_clk_oe;
  logic                ps2_data_oe;
  logic                ps2_data_out;
  ps2_pkg::ps2_byte_t  rx_data;
  logic                rx_valid;
  logic                busy;
  logic                err;
  logic                test_start;
  logic                test_end;
  int                  test_kind;
  ps2_pkg::ps2_byte_t  exp_byte;
  ps2_pkg::ps2_frame_t exp_frame;
  ps2_pkg::ps2_frame_t dev_frame;
  int                  pass_cnt;
  int                  fail_cnt;
  int                  cycle_cnt = 0;
  int                  seed;
  logic [31:0]         rnd;
  ps2_pkg::ps2_byte_t  b;
  ps2_pkg::ps2_byte_t  last_rx;

  // open collector bus where low wins
  assign ps2_clk_line  = dev_clk & ~ps2_clk_oe;
  assign ps2_data_line = dev_data & ~(ps2_data_oe & ~ps2_data_out);

  ps2_clk_gen #(.period_ns(40), .rst_cycles(8)) i_clk_gen (.clk(clk), .rst(rst));

  ps2_host #(
    .rts_hold_cycles(rts_hold), .data_setup_cycles(data_setup),
    .release_cycles(release_c), .debounce_cycles(debounce)
  ) i_dut (
    .clk(clk), .rst(rst), .ps2_clk_in(ps2_clk_line), .ps2_data_in(ps2_data_line),
    .tx_data(tx_data), .tx_valid(tx_valid), .ps2_clk_oe(ps2_clk_oe),
    .ps2_data_oe(ps2_data_oe), .ps2_data_out(ps2_data_out), .rx_data(rx_data),
    .rx_valid(rx_valid), .busy(busy), .err(err)
  );

  ps2_host_checker #(.rts_hold_cycles(rts_hold), .data_setup_cycles(data_setup)) i_checker (
    .clk(clk), .test_start(test_start), .test_end(test_end), .test_kind(test_kind),
    .exp_byte(exp_byte), .exp_frame(exp_frame), .dev_frame(dev_frame), .rx_data(rx_data),
    .rx_valid(rx_valid), .err(err), .busy(busy), .ps2_clk_oe(ps2_clk_oe),
    .ps2_data_oe(ps2_data_oe), .ps2_data_out(ps2_data_out),
    .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
  );

  ////////////////////////////// reference model
  // start 0, data lsb first, odd parity, stop 1
  function automatic ps2_pkg::ps2_frame_t expected_frame(input ps2_pkg::ps2_byte_t data);
    logic par;
    par = 1'b1;
    for (int i = 0; i < 8; i++) par = par ^ data[i];
    return {1'b1, par, data, 1'b0};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic begin_test(input int kind);
    @(posedge clk);
    test_kind  <= kind;
    test_start <= 1'b1;
    @(posedge clk);
    test_start <= 1'b0;
  endtask

  task automatic end_test();
    @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  // device to host with data changing in the middle of clock high
  task automatic device_send(input ps2_pkg::ps2_frame_t frame);
    for (int i = 0; i < 11; i++) begin
      dev_data <= frame[i];
      wait_cycles(half_clk / 2);
      dev_clk <= 1'b0;
      wait_cycles(half_clk);
      dev_clk <= 1'b1;
      wait_cycles(half_clk / 2);
    end
    dev_data <= 1'b1;
  endtask

  // host to device where the device samples on its rising edges
  task automatic host_send(input ps2_pkg::ps2_byte_t data, input logic ack);
    @(posedge clk);
    tx_data  <= data;
    tx_valid <= 1'b1;
    @(posedge clk);
    tx_valid <= 1'b0;
    while (!ps2_clk_oe) @(negedge clk);
    while (ps2_clk_oe) @(negedge clk);
    dev_frame[0] = ps2_data_line;     // start bit at release
    wait_cycles(half_clk);
    for (int i = 1; i < 11; i++) begin
      dev_clk <= 1'b0;
      wait_cycles(half_clk);
      @(negedge clk) dev_frame[i] = ps2_data_line;
      @(posedge clk) dev_clk <= 1'b1;
      wait_cycles(half_clk);
    end
    dev_data <= !ack;                 // ack pulls data low
    wait_cycles(half_clk / 2);
    dev_clk <= 1'b0;
    wait_cycles(half_clk);
    dev_clk <= 1'b1;
    wait_cycles(half_clk / 2);
    dev_data <= 1'b1;
    while (busy) @(negedge clk);
  endtask

  ////////////////////////////// stimulus
  initial begin
    seed       = 47653;
    tx_valid   = 1'b0;
    tx_data    = '0;
    dev_clk    = 1'b1;
    dev_data   = 1'b1;
    test_start = 1'b0;
    test_end   = 1'b0;
    test_kind  = 0;
    exp_byte   = '0;
    exp_frame  = '0;
    dev_frame  = '0;
    last_rx    = '0;
    while (rst) @(posedge clk);
    begin_test(0);
    wait_cycles(4);
    end_test();
    repeat (4) begin
      rnd = $random(seed);
      b   = rnd[7:0];
      exp_byte <= b;
      begin_test(1);
      device_send(expected_frame(b));
      wait_cycles(2 * half_clk);
      end_test();
      last_rx = b;
    end
    rnd = $random(seed);
    b   = rnd[7:0];
    exp_byte <= last_rx;              // a dropped frame leaves rx_data alone
    begin_test(2);
    device_send(expected_frame(b) ^ 11'h200);
    wait_cycles(2 * half_clk);
    end_test();
    for (int k = 3; k < 6; k++) begin
      rnd = $random(seed);
      b   = rnd[7:0];
      exp_frame <= expected_frame(b);
      begin_test(k);
      host_send(b, k != 5);
      wait_cycles(10);
      end_test();
    end
    wait_cycles(2);
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n_tests) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout after %0d cycles, the DUT never finished the test", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps2_frame_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_frame_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               frame_load,   // capture tx_data this cycle
  input  ps2_pkg::ps2_byte_t tx_data,
  input  logic               frame_shift,  // one bit in or out
  input  logic               data_s,       // debounced data line
  input  logic               rx_done,      // frame complete and parity good
  output logic               tx_bit,
  output logic               parity_ok,
  output ps2_pkg::ps2_byte_t rx_data,
  output logic               rx_valid
);

  ps2_pkg::ps2_frame_t frame;       // bit 0 is the start bit
  ps2_pkg::ps2_byte_t  frame_byte;  // data field of the frame
  logic                frame_par;   // parity field

  //////////////////////////////
  // shared shift path
  // receive fills from the top so the first bit ends up in bit 0
  // transmit drains from bit 0
  always_ff @(posedge clk) begin
    if (frame_load) begin
      frame <= {1'b1, ps2_pkg::odd_parity(tx_data), tx_data, 1'b0};  // stop par data start
    end else if (frame_shift) begin
      frame <= {data_s, frame[10:1]};
    end
  end

  assign frame_byte = frame[8:1];
  assign frame_par  = frame[9];
  assign tx_bit     = frame[0];  // next bit for the data line

  assign parity_ok = (frame_par == ps2_pkg::odd_parity(frame_byte));

  ////////////////////////////// byte to the client
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_data  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= rx_done;        // single cycle strobe
      if (rx_done) begin
        rx_data <= frame_byte;    // last byte wins
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps2_host.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host #(
  parameter int unsigned rts_hold_cycles   = ps2_pkg::default_rts_hold_cycles,
  parameter int unsigned data_setup_cycles = ps2_pkg::default_data_setup_cycles,
  parameter int unsigned release_cycles    = ps2_pkg::default_release_cycles,
  parameter int unsigned debounce_cycles   = ps2_pkg::default_debounce_cycles
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ps2_clk_in,    // clock line as seen at the pad
  input  logic               ps2_data_in,
  input  ps2_pkg::ps2_byte_t tx_data,
  input  logic               tx_valid,
  output logic               ps2_clk_oe,    // pad drives clock low
  output logic               ps2_data_oe,
  output logic               ps2_data_out,
  output ps2_pkg::ps2_byte_t rx_data,
  output logic               rx_valid,
  output logic               busy,
  output logic               err
);

  logic                    clk_s;
  logic                    data_s;
  logic                    delay_run;
  ps2_pkg::ps2_delay_sel_t delay_sel;
  logic                    in_idle;
  logic                    bit_step;
  logic                    delay_done;
  logic                    rx_last;
  logic                    tx_last;
  logic                    frame_load;
  logic                    frame_shift;
  logic                    rx_done;
  logic                    tx_bit;
  logic                    parity_ok;

  ////////////////////////////// line conditioning
  ps2_line_filter #(.debounce_cycles(debounce_cycles)) i_clk_filter (
    .clk(clk), .rst(rst), .line_in(ps2_clk_in), .line_s(clk_s)
  );

  ps2_line_filter #(.debounce_cycles(debounce_cycles)) i_data_filter (
    .clk(clk), .rst(rst), .line_in(ps2_data_in), .line_s(data_s)
  );

  ps2_timer #(
    .rts_hold_cycles(rts_hold_cycles),
    .data_setup_cycles(data_setup_cycles),
    .release_cycles(release_cycles)
  ) i_timer (
    .clk(clk), .rst(rst), .delay_run(delay_run), .delay_sel(delay_sel),
    .in_idle(in_idle), .bit_step(bit_step), .delay_done(delay_done),
    .rx_last(rx_last), .tx_last(tx_last)
  );

  ps2_frame_reg i_frame (
    .clk(clk), .rst(rst), .frame_load(frame_load), .tx_data(tx_data),
    .frame_shift(frame_shift), .data_s(data_s), .rx_done(rx_done),
    .tx_bit(tx_bit), .parity_ok(parity_ok), .rx_data(rx_data), .rx_valid(rx_valid)
  );

  ps2_host_fsm i_fsm (
    .clk(clk), .rst(rst), .tx_valid(tx_valid), .clk_s(clk_s), .data_s(data_s),
    .delay_done(delay_done), .rx_last(rx_last), .tx_last(tx_last),
    .parity_ok(parity_ok), .tx_bit(tx_bit), .delay_run(delay_run),
    .delay_sel(delay_sel), .in_idle(in_idle), .bit_step(bit_step),
    .frame_load(frame_load), .frame_shift(frame_shift), .rx_done(rx_done),
    .ps2_clk_oe(ps2_clk_oe), .ps2_data_oe(ps2_data_oe),
    .ps2_data_out(ps2_data_out), .busy(busy), .err(err)
  );

endmodule

`default_nettype wire

//--- hdl/ps2_host_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    tx_valid,
  input  logic                    clk_s,
  input  logic                    data_s,
  input  logic                    delay_done,
  input  logic                    rx_last,
  input  logic                    tx_last,
  input  logic                    parity_ok,
  input  logic                    tx_bit,
  output logic                    delay_run,
  output ps2_pkg::ps2_delay_sel_t delay_sel,
  output logic                    in_idle,
  output logic                    bit_step,
  output logic                    frame_load,
  output logic                    frame_shift,
  output logic                    rx_done,
  output logic                    ps2_clk_oe,   // pull clock low
  output logic                    ps2_data_oe,
  output logic                    ps2_data_out,
  output logic                    busy,
  output logic                    err
);

  ps2_pkg::ps2_state_t     state;
  ps2_pkg::ps2_state_t     state_next;
  ps2_pkg::ps2_delay_sel_t delay_sel_next;
  logic                    delay_run_next;
  logic                    data_oe_next;
  logic                    data_out_next;
  logic                    err_next;

  assign in_idle     = (state == ps2_pkg::idle);
  assign frame_load  = in_idle && tx_valid;  // tx_data only held with the request
  assign frame_shift = (state == ps2_pkg::rx_neg_edge) || (state == ps2_pkg::tx_clk_low);
  assign bit_step    = frame_shift;          // every shift is one frame bit

  ////////////////////////////// next state
  always_comb begin
    state_next     = state;
    delay_run_next = 1'b0;  // dropping run for a cycle clears the timer
    err_next       = 1'b0;
    rx_done        = 1'b0;
    case (state)
      ps2_pkg::idle: begin
        if (tx_valid) begin                 // host send wins over device clock
          state_next     = ps2_pkg::tx_force_clk_low;
          delay_run_next = 1'b1;
        end else if (!clk_s) begin
          state_next = ps2_pkg::rx_neg_edge;
        end
      end
      ps2_pkg::rx_neg_edge: state_next = ps2_pkg::rx_clk_low;  // bit sampled here
      ps2_pkg::rx_clk_low:  if (clk_s) state_next = ps2_pkg::rx_clk_high;
      ps2_pkg::rx_clk_high: begin
        if (rx_last) begin
          state_next = ps2_pkg::idle;
          rx_done    = parity_ok;
          err_next   = !parity_ok;          // bad parity drops the byte
        end else if (!clk_s) begin
          state_next = ps2_pkg::rx_neg_edge;
        end
      end
      ps2_pkg::tx_force_clk_low: begin
        if (delay_done) state_next = ps2_pkg::tx_bring_data_low;
        else delay_run_next = 1'b1;
      end
      ps2_pkg::tx_bring_data_low: begin
        if (delay_done) state_next = ps2_pkg::tx_release_clk;
        else delay_run_next = 1'b1;
      end
      ps2_pkg::tx_release_clk: begin        // device reads the start bit now
        state_next     = ps2_pkg::tx_wait_first_neg_edge;
        delay_run_next = 1'b1;
      end
      ps2_pkg::tx_wait_first_neg_edge: begin  // filtered clock lags the release
        if (delay_done && !clk_s) state_next = ps2_pkg::tx_clk_low;
        else delay_run_next = 1'b1;
      end
      ps2_pkg::tx_clk_low: state_next = ps2_pkg::tx_wait_pos_edge;
      ps2_pkg::tx_wait_pos_edge: begin
        if (tx_last) state_next = ps2_pkg::tx_wait_pos_edge_before_ack;  // stop bit is the released line
        else if (clk_s) state_next = ps2_pkg::tx_clk_high;
      end
      ps2_pkg::tx_clk_high: if (!clk_s) state_next = ps2_pkg::tx_clk_low;
      ps2_pkg::tx_wait_pos_edge_before_ack: if (clk_s) state_next = ps2_pkg::tx_wait_ack;
      ps2_pkg::tx_wait_ack: begin
        if (!clk_s) begin                   // ack is data low at the clock fall
          state_next = data_s ? ps2_pkg::tx_error_no_ack : ps2_pkg::tx_received_ack;
        end
      end
      ps2_pkg::tx_received_ack: if (clk_s && data_s) state_next = ps2_pkg::idle;
      ps2_pkg::tx_error_no_ack: begin
        if (clk_s && data_s) begin          // report once the bus is free
          state_next = ps2_pkg::idle;
          err_next   = 1'b1;
        end
      end
      default: state_next = ps2_pkg::idle;  // unused code
    endcase
  end

  ////////////////////////////// line and timer controls from next state
  always_comb begin
    case (state_next)
      ps2_pkg::tx_force_clk_low:  delay_sel_next = ps2_pkg::delay_rts_hold;
      ps2_pkg::tx_bring_data_low: delay_sel_next = ps2_pkg::delay_data_setup;
      default:                    delay_sel_next = ps2_pkg::delay_release;
    endcase
    case (state_next)
      ps2_pkg::tx_bring_data_low, ps2_pkg::tx_release_clk,
      ps2_pkg::tx_wait_first_neg_edge: begin
        data_oe_next  = 1'b1;
        data_out_next = 1'b0;    // start bit during the request
      end
      ps2_pkg::tx_clk_low, ps2_pkg::tx_wait_pos_edge, ps2_pkg::tx_clk_high: begin
        data_oe_next  = 1'b1;
        data_out_next = tx_bit;
      end
      default: begin
        data_oe_next  = 1'b0;    // released and pulled up
        data_out_next = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= ps2_pkg::idle;
      delay_run    <= 1'b0;
      delay_sel    <= ps2_pkg::delay_rts_hold;
      ps2_clk_oe   <= 1'b0;
      ps2_data_oe  <= 1'b0;
      ps2_data_out <= 1'b1;
      busy         <= 1'b0;
      err          <= 1'b0;
    end else begin
      state        <= state_next;
      delay_run    <= delay_run_next;
      delay_sel    <= delay_sel_next;
      ps2_clk_oe   <= (state_next == ps2_pkg::tx_force_clk_low) ||
                      (state_next == ps2_pkg::tx_bring_data_low);
      ps2_data_oe  <= data_oe_next;
      ps2_data_out <= data_out_next;
      busy         <= (state_next != ps2_pkg::idle);
      err          <= err_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps2_line_filter.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_line_filter #(
  parameter int unsigned debounce_cycles = ps2_pkg::default_debounce_cycles
) (
  input  logic clk,
  input  logic rst,
  input  logic line_in,   // raw open-collector line
  output logic line_s     // clean level in the clk domain
);

  logic                sync_q;      // first flop on the async line
  logic                cand;        // level being qualified
  ps2_pkg::ps2_delay_t stable_cnt;  // cycles the candidate has held

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_q <= 1'b1;  // bus idles high
    end else begin
      sync_q <= line_in;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cand       <= 1'b1;
      stable_cnt <= '0;
      line_s     <= 1'b1;
    end else if (sync_q != cand) begin
      cand       <= sync_q;  // new level seen so qualify it again
      stable_cnt <= '0;
    end else if (stable_cnt == ps2_pkg::ps2_delay_t'(debounce_cycles)) begin
      line_s <= cand;        // held long enough
    end else begin
      stable_cnt <= stable_cnt + ps2_pkg::ps2_delay_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  ////////////////////////////// widths
  typedef logic [7:0]  ps2_byte_t;     // one data byte
  typedef logic [10:0] ps2_frame_t;    // start + 8 data + parity + stop
  typedef logic [13:0] ps2_delay_t;    // covers 100 us at 100 MHz
  typedef logic [3:0]  ps2_bit_cnt_t;  // bits seen in the current frame

  // host sequencer states
  typedef enum logic [3:0] {
    idle,
    rx_neg_edge, rx_clk_low, rx_clk_high,
    tx_force_clk_low, tx_bring_data_low, tx_release_clk, tx_wait_first_neg_edge,
    tx_clk_low, tx_wait_pos_edge, tx_clk_high, tx_wait_pos_edge_before_ack,
    tx_wait_ack, tx_received_ack, tx_error_no_ack
  } ps2_state_t;

  // which protocol delay the timer is measuring
  typedef enum logic [1:0] {
    delay_rts_hold,    // clock held low by the host
    delay_data_setup,  // data low before clock release
    delay_release      // let the clock line settle
  } ps2_delay_sel_t;

  ////////////////////////////// frame and timing constants
  localparam int unsigned frame_bits    = 11;  // bits per received frame
  localparam int unsigned tx_shift_bits = 10;  // start bit leaves during the request

  localparam int unsigned default_rts_hold_cycles   = 10000;
  localparam int unsigned default_data_setup_cycles = 2000;
  localparam int unsigned default_release_cycles    = 63;
  localparam int unsigned default_debounce_cycles   = 15;

  // parity bit that makes the nine bits carry an odd number of ones
  function automatic logic odd_parity(input ps2_byte_t data);
    return ~^data;
  endfunction

endpackage

`default_nettype wire

//--- hdl/ps2_timer.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_timer #(
  parameter int unsigned rts_hold_cycles   = ps2_pkg::default_rts_hold_cycles,
  parameter int unsigned data_setup_cycles = ps2_pkg::default_data_setup_cycles,
  parameter int unsigned release_cycles    = ps2_pkg::default_release_cycles
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    delay_run,
  input  ps2_pkg::ps2_delay_sel_t delay_sel,
  input  logic                    in_idle,
  input  logic                    bit_step,
  output logic                    delay_done,
  output logic                    rx_last,
  output logic                    tx_last
);

  ps2_pkg::ps2_delay_t   delay_cnt;
  ps2_pkg::ps2_delay_t   delay_limit;
  ps2_pkg::ps2_bit_cnt_t bit_cnt;

  ////////////////////////////// protocol delays
  always_comb begin
    case (delay_sel)
      ps2_pkg::delay_rts_hold:   delay_limit = ps2_pkg::ps2_delay_t'(rts_hold_cycles);
      ps2_pkg::delay_data_setup: delay_limit = ps2_pkg::ps2_delay_t'(data_setup_cycles);
      default:                   delay_limit = ps2_pkg::ps2_delay_t'(release_cycles);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      delay_cnt <= '0;
    end else if (!delay_run) begin
      delay_cnt <= '0;                                     // one idle cycle clears it
    end else if (delay_cnt != delay_limit) begin
      delay_cnt <= delay_cnt + ps2_pkg::ps2_delay_t'(1);  // stop at the limit
    end
  end

  assign delay_done = delay_run && (delay_cnt == delay_limit);

  ////////////////////////////// frame bit count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (in_idle) begin
      bit_cnt <= '0;
    end else if (bit_step) begin
      bit_cnt <= bit_cnt + ps2_pkg::ps2_bit_cnt_t'(1);
    end
  end

  assign rx_last = (bit_cnt == ps2_pkg::ps2_bit_cnt_t'(ps2_pkg::frame_bits));
  assign tx_last = (bit_cnt == ps2_pkg::ps2_bit_cnt_t'(ps2_pkg::tx_shift_bits));

endmodule

`default_nettype wire

//--- ps2_host.f
hdl/ps2_pkg.sv
hdl/ps2_line_filter.sv
hdl/ps2_timer.sv
hdl/ps2_frame_reg.sv
hdl/ps2_host_fsm.sv
hdl/ps2_host.sv
dv/ps2_clk_gen.sv
dv/ps2_host_asserts.sv
dv/ps2_host_checker.sv
dv/ps2_host_tb.sv
